/* src/video_timing_pkg.sv */
// ######################################
// video timing definitions
// segments, boundaries and levels of one composite video line
// ######################################
`default_nettype none

package video_timing_pkg;

   // segments in the order they appear on a line
   typedef enum logic [2:0]
   {
      SEG_SYNC,     // sync tip, encoded as zero so a cleared pipe reads as sync
      SEG_BACK,     // back porch before the burst
      SEG_BURST,    // colour burst, 9 subcarrier cycles
      SEG_BREEZE,   // gap between burst and picture
      SEG_ACTIVE,   // visible pixels
      SEG_FRONT     // front porch up to the next sync
   } segment_t;

   // boundaries in subcarrier ticks, 16 ticks per cycle
   localparam int SYNC_END     = 269;   // first tick after sync
   localparam int BURST_START  = 304;
   localparam int BURST_END    = 448;   // 144 ticks = 9 cycles
   localparam int ACTIVE_START = 560;
   localparam int FRONT_PORCH  = 96;    // active ends this far before line end

   // output levels
   localparam logic [5:0] LUMA_SYNC   = 6'd0;
   localparam logic [5:0] LUMA_BLANK  = 6'd12;   // blanking / black
   localparam logic [5:0] CHROMA_MID  = 6'd32;   // zero chroma swing
   localparam logic [3:0] BURST_PHASE = 4'd8;    // half a cycle, 180 deg
   localparam logic [3:0] BURST_AMP   = 4'd6;

   // side info that rides next to the pixel pipeline
   typedef struct packed
   {
      segment_t segment;
      logic     burst;    // burst window flag
   } seg_info_t;

endpackage

`default_nettype wire

/* src/palette_pkg.sv */
// ######################################
// palette definitions
// colour and level types, palette word, register map, sine table
// ######################################
`default_nettype none

package palette_pkg;

   typedef logic [3:0] color_t;   // colour index from the pixel path
   typedef logic [5:0] level_t;   // 6 bit dac level
   typedef logic [3:0] phase_t;   // 1/16 of a subcarrier cycle per step
   typedef logic [3:0] amp_t;     // chroma amplitude

   // palette word as seen on the bus, bits 31..16 read 0
   typedef struct packed
   {
      amp_t       amp;     // 15..12
      phase_t     phase;   // 11..8
      logic [1:0] rsvd;    // 7..6, always 0
      level_t     luma;    // 5..0
   } pal_word_t;

   localparam int PAL_ENTRIES = 16;

   // register map, entry k sits at byte 4k
   localparam logic [7:0] CTRL_ADDR   = 8'h40;
   localparam int         CTRL_EN_BIT = 0;     // palette output enable

   // round(16 * sin(2 pi k / 16))
   typedef logic signed [5:0] sine_t;
   localparam sine_t SINE_TAB [16] = '{
      6'sd0,  6'sd6,  6'sd11,  6'sd15,  6'sd16,  6'sd15,  6'sd11,  6'sd6,
      6'sd0, -6'sd6, -6'sd11, -6'sd15, -6'sd16, -6'sd15, -6'sd11, -6'sd6
   };

endpackage

`default_nettype wire

/* src/seg_if.sv */
// ######################################
// segment bus
// line segment state from sequencer to modulator
// ######################################
`default_nettype none
`timescale 1ns/1ns

interface seg_if;
   import video_timing_pkg::*;
   import palette_pkg::*;

   segment_t segment;     // current segment
   logic     burst;       // burst window
   logic     sync;        // sync tip
   logic     pixel_req;   // pixel_color is sampled this cycle
   phase_t   phase;       // subcarrier phase aligned with the segment

   // sequencer side
   modport seq (output segment, burst, sync, pixel_req, phase);

   // modulator side
   modport mod (input segment, burst, sync, pixel_req, phase);

endinterface

`default_nettype wire

/* src/palette_if.sv */
// ######################################
// palette lookup bus
// colour index out, stored palette fields back
// ######################################
`default_nettype none
`timescale 1ns/1ns

interface palette_if;
   import palette_pkg::*;

   color_t color;    // index to look up
   level_t luma;     // luma of that entry
   phase_t phase;    // hue as phase offset
   amp_t   amp;      // saturation
   logic   enable;   // CTRL enable bit

   // register file answers combinationally
   modport regs (input color, output luma, phase, amp, enable);

   // modulator asks
   modport mod (output color, input luma, phase, amp, enable);

endinterface

`default_nettype wire

/* src/palette_regs.sv */
// ######################################
// palette register file
// APB slave with 16 palette words and CTRL
// ######################################
`default_nettype none
`timescale 1ns/1ns

module palette_regs
(
   input  wire          clk_col16x_ntsc,
   input  wire          rst,
   input  wire   [7:0]  paddr,
   input  wire          psel,
   input  wire          penable,
   input  wire          pwrite,
   input  wire   [31:0] pwdata,
   output logic  [31:0] prdata,
   output logic         pready,
   output logic         pslverr,
   palette_if.regs      pal
);
   import palette_pkg::*;

   pal_word_t  words [PAL_ENTRIES];   // palette storage
   logic       enable_q;              // CTRL bit 0
   logic       addr_err;              // outside the map or unaligned
   logic       is_ctrl;
   logic       wr_en;
   logic       rd_en;
   logic [3:0] idx;                   // palette entry from the byte address

   assign addr_err = (paddr[1:0] != 2'b00) || (paddr > CTRL_ADDR);
   assign is_ctrl  = (paddr == CTRL_ADDR);
   assign idx      = paddr[5:2];

   assign wr_en = psel && penable && pwrite && !addr_err;   // access phase only
   assign rd_en = psel && !pwrite && !addr_err;

   // zero wait states, error flagged in the access phase
   assign pready  = 1'b1;
   assign pslverr = psel && penable && addr_err;

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         for (int k = 0; k < PAL_ENTRIES; k++)
            words[k] <= '0;
         enable_q <= 1'b0;
      end
      else if (wr_en)
      begin
         if (is_ctrl)
            enable_q <= pwdata[CTRL_EN_BIT];
         else
            words[idx] <= '{amp: pwdata[15:12], phase: pwdata[11:8],
                            rsvd: 2'b00, luma: pwdata[5:0]};   // unused bits dropped
      end
   end

   // read mux, errors and unused bits read 0
   always_comb
   begin
      prdata = '0;
      if (rd_en)
      begin
         if (is_ctrl)
            prdata[CTRL_EN_BIT] = enable_q;
         else
            prdata[15:0] = words[idx];
      end
   end

   // lookup port for the modulator
   assign pal.luma   = words[pal.color].luma;
   assign pal.phase  = words[pal.color].phase;
   assign pal.amp    = words[pal.color].amp;
   assign pal.enable = enable_q;

endmodule

`default_nettype wire

/* src/line_timer.sv */
// ######################################
// line timer
// tick within the line and free running subcarrier phase
// ######################################
`default_nettype none
`timescale 1ns/1ns

module line_timer
#(
   parameter int LINE_TICKS = 3640   // 227.5 subcarrier cycles for NTSC
)
(
   input  wire                 clk_col16x_ntsc,
   input  wire                 rst,
   output logic [15:0]         tick,    // 0 .. LINE_TICKS-1
   output palette_pkg::phase_t phase    // 16 steps per subcarrier cycle
);

   localparam logic [15:0] LAST_TICK = 16'(LINE_TICKS - 1);

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         tick  <= '0;
         phase <= '0;
      end
      else
      begin
         // line counter
         if (tick == LAST_TICK)
            tick <= '0;
         else
            tick <= tick + 16'd1;

         // subcarrier keeps running across lines, with 3640 ticks
         // each line starts half a cycle away from the previous one
         phase <= phase + 4'd1;
      end
   end

endmodule

`default_nettype wire

/* src/line_sequencer.sv */
// ######################################
// line sequencer
// steps through the line segments and raises pixel_req
// ######################################
`default_nettype none
`timescale 1ns/1ns

module line_sequencer
#(
   parameter int LINE_TICKS = 3640
)
(
   input  wire                 clk_col16x_ntsc,
   input  wire                 rst,
   input  wire [15:0]          tick,
   input  wire palette_pkg::phase_t phase,
   seg_if.seq                  seg
);
   import video_timing_pkg::*;

   localparam int ACTIVE_END = LINE_TICKS - FRONT_PORCH;   // first front porch tick

   segment_t state_q;   // segment of the previous tick
   segment_t state_n;

   // next segment from the tick just counted
   always_comb
   begin
      state_n = state_q;
      if (tick == 16'd0)
         state_n = SEG_SYNC;   // wrap, new line
      else
      begin
         case (state_q)
            SEG_SYNC:
               if (tick == 16'(SYNC_END))
                  state_n = SEG_BACK;
            SEG_BACK:
               if (tick == 16'(BURST_START))
                  state_n = SEG_BURST;
            SEG_BURST:
               if (tick == 16'(BURST_END))
                  state_n = SEG_BREEZE;
            SEG_BREEZE:
               if (tick == 16'(ACTIVE_START))
                  state_n = SEG_ACTIVE;
            SEG_ACTIVE:
               if (tick == 16'(ACTIVE_END))
                  state_n = SEG_FRONT;
            SEG_FRONT:
               state_n = SEG_FRONT;   // hold until wrap
            default:
               state_n = SEG_SYNC;
         endcase
      end
   end

   // everything leaves one cycle after its tick
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         state_q       <= SEG_SYNC;
         seg.burst     <= 1'b0;
         seg.sync      <= 1'b1;   // matches the sync state
         seg.pixel_req <= 1'b0;
      end
      else
      begin
         state_q       <= state_n;
         seg.burst     <= (state_n == SEG_BURST);
         seg.sync      <= (state_n == SEG_SYNC);
         seg.pixel_req <= (state_n == SEG_ACTIVE);
      end
   end

   // phase travels beside the segment
   always_ff @(posedge clk_col16x_ntsc)
      seg.phase <= phase;

   assign seg.segment = state_q;

endmodule

`default_nettype wire

/* src/video_delay.sv */
// ######################################
// video delay line
// fixed depth shift register for any payload type
// ######################################
`default_nettype none
`timescale 1ns/1ns

module video_delay
#(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 2   // clocks of delay, at least 1
)
(
   input  wire           clk_col16x_ntsc,
   input  wire           rst,
   input  wire payload_t din,
   output payload_t      dout
);

   payload_t stage_q [DEPTH];   // stage_q[0] is the newest

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         for (int i = 0; i < DEPTH; i++)
            stage_q[i] <= '0;   // zero payload
      end
      else
      begin
         stage_q[0] <= din;
         for (int i = 1; i < DEPTH; i++)
            stage_q[i] <= stage_q[i-1];
      end
   end

   assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

/* src/chroma_modulator.sv */
// ######################################
// chroma modulator
// palette lookup, sine multiply and level select in two stages
// ######################################
`default_nettype none
`timescale 1ns/1ns

module chroma_modulator
(
   input  wire                      clk_col16x_ntsc,
   input  wire                      rst,
   input  wire palette_pkg::color_t pixel_color,
   seg_if.mod                       seg,
   palette_if.mod                   pal,
   output palette_pkg::level_t      luma,
   output palette_pkg::level_t      chroma,
   output logic                     luma_sink   // current sink during sync
);
   import video_timing_pkg::*;
   import palette_pkg::*;

   seg_info_t         seg_info;     // side info into stage 1
   seg_info_t         seg_d;        // side info at stage 2
   level_t            luma_in;
   level_t            luma_d;
   phase_t            ph_idx_r;     // sine table index
   amp_t              amp_r;
   logic              vis_r;        // active pixel with palette enabled
   logic signed [9:0] prod;         // amp * sine, -240 .. 240
   logic [5:0]        offset;       // floor(prod / 16)
   level_t            chroma_mod;

   assign pal.color = pixel_color;  // lookup of the colour being sampled

   assign seg_info.segment = seg.segment;
   assign seg_info.burst   = seg.burst;
   assign luma_in          = seg.sync ? LUMA_SYNC : pal.luma;

   video_delay #(.payload_t(seg_info_t), .DEPTH(1)) seg_dly
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .din            (seg_info),
      .dout           (seg_d)
   );

   video_delay #(.payload_t(level_t), .DEPTH(1)) luma_dly
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .din            (luma_in),
      .dout           (luma_d)
   );

   // stage 1, burst uses fixed phase and amplitude
   always_ff @(posedge clk_col16x_ntsc)
   begin
      ph_idx_r <= seg.phase + (seg.burst ? BURST_PHASE : pal.phase);   // mod 16
      amp_r    <= seg.burst ? BURST_AMP : pal.amp;
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
         vis_r <= 1'b0;
      else
         vis_r <= seg.pixel_req && pal.enable;
   end

   // stage 2 arithmetic
   assign prod       = $signed({1'b0, amp_r}) * SINE_TAB[ph_idx_r];
   assign offset     = prod[9:4];               // arithmetic shift by 4
   assign chroma_mod = CHROMA_MID + offset;     // wraps to 17 .. 47

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         luma      <= LUMA_BLANK;
         chroma    <= CHROMA_MID;
         luma_sink <= 1'b0;
      end
      else
      begin
         luma_sink <= (seg_d.segment == SEG_SYNC);
         if ((seg_d.segment == SEG_SYNC) || vis_r)
            luma <= luma_d;       // sync tip or palette luma
         else
            luma <= LUMA_BLANK;
         if (seg_d.burst || vis_r)
            chroma <= chroma_mod;
         else
            chroma <= CHROMA_MID; // no swing outside burst and picture
      end
   end

endmodule

`default_nettype wire

/* src/kawari_chroma.sv */
// ######################################
// luma/chroma encoder top
// APB palette, line timing and subcarrier modulation
// ######################################
`default_nettype none
`timescale 1ns/1ns

module kawari_chroma
#(
   parameter int LINE_TICKS = 3640   // ticks per line, shorter for test
)
(
   input  wire                      clk_col16x_ntsc,
   input  wire                      rst,
   input  wire palette_pkg::color_t pixel_color,
   input  wire  [7:0]               paddr,
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire  [31:0]              pwdata,
   output logic [31:0]              prdata,
   output logic                     pready,
   output logic                     pslverr,
   output logic                     pixel_req,
   output palette_pkg::level_t      luma,
   output palette_pkg::level_t      chroma,
   output logic                     luma_sink
);
   import palette_pkg::*;

   logic [15:0] tick;    // position in the line
   phase_t      phase;   // raw subcarrier phase

   seg_if     seg_bus ();
   palette_if pal_bus ();

   palette_regs regs0
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .pal            (pal_bus.regs)
   );

   line_timer #(.LINE_TICKS(LINE_TICKS)) timer0
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .tick           (tick),
      .phase          (phase)
   );

   line_sequencer #(.LINE_TICKS(LINE_TICKS)) seq0
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .tick           (tick),
      .phase          (phase),
      .seg            (seg_bus.seq)
   );

   chroma_modulator mod0
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .pixel_color    (pixel_color),
      .seg            (seg_bus.mod),
      .pal            (pal_bus.mod),
      .luma           (luma),
      .chroma         (chroma),
      .luma_sink      (luma_sink)
   );

   assign pixel_req = seg_bus.pixel_req;   // to the pixel source

endmodule

`default_nettype wire

/* tb/chroma_ref.svh */
// ######################################
// reference model for the luma/chroma encoder
// expected segment, levels and strobes per sample
// ######################################
`ifndef CHROMA_REF_SVH
`define CHROMA_REF_SVH

// what the outputs must show 2 clocks after a sample
typedef struct packed
{
   logic        valid;     // sample already driven by the running line
   logic [15:0] tick;      // line tick the sample belongs to
   logic        req;       // pixel_req seen with this sample
   logic        sink;
   logic        visible;   // palette colour goes to the screen
   logic [5:0]  luma;
   logic [5:0]  chroma;
} expect_t;

// segment of a line tick
function automatic segment_t ref_segment(input int t, input int line_ticks);
   segment_t s;
   if (t < SYNC_END)
      s = SEG_SYNC;
   else if (t < BURST_START)
      s = SEG_BACK;
   else if (t < BURST_END)
      s = SEG_BURST;
   else if (t < ACTIVE_START)
      s = SEG_BREEZE;
   else if (t < line_ticks - FRONT_PORCH)
      s = SEG_ACTIVE;
   else
      s = SEG_FRONT;
   return s;
endfunction

// round(16 sin(2 pi k / 16))
function automatic int ref_sine(input int k);
   int s;
   case (k % 16)
      0, 8:   s = 0;
      1, 7:   s = 6;
      2, 6:   s = 11;
      3, 5:   s = 15;
      4:      s = 16;
      9, 15:  s = -6;
      10, 14: s = -11;
      11, 13: s = -15;
      default: s = -16;   // k = 12
   endcase
   return s;
endfunction

// 32 + floor(amp * sine / 16)
function automatic int ref_chroma(input int amp, input int idx);
   int prod;
   int off;
   int mid;
   prod = amp * ref_sine(idx);
   off  = prod >>> 4;   // floor toward minus infinity
   mid  = CHROMA_MID;
   return mid + off;
endfunction

// full expectation for one sample, word holds the palette entry of the colour
function automatic expect_t ref_expect(input int t, input int ph, input logic [15:0] word,
                                       input logic en, input int line_ticks);
   expect_t  e;
   segment_t s;
   s         = ref_segment(t, line_ticks);
   e         = '0;
   e.valid   = 1'b1;
   e.tick    = 16'(t);
   e.req     = (s == SEG_ACTIVE);
   e.luma    = LUMA_BLANK;
   e.chroma  = CHROMA_MID;
   case (s)
      SEG_SYNC:
      begin
         e.luma = LUMA_SYNC;
         e.sink = 1'b1;
      end
      SEG_BURST:
         e.chroma = 6'(ref_chroma(BURST_AMP, (ph + BURST_PHASE) % 16));
      SEG_ACTIVE:
         if (en)
         begin
            e.visible = 1'b1;
            e.luma    = word[5:0];
            e.chroma  = 6'(ref_chroma(word[15:12], (ph + word[11:8]) % 16));
         end
      default:
         e.sink = 1'b0;   // blank levels already set
   endcase
   return e;
endfunction

`endif

/* tb/tb_kawari_chroma.sv */
// ######################################
// testbench for the luma/chroma encoder
// APB palette set-up, random pixels, compare every clock
// ######################################
`default_nettype none
`timescale 1ns/1ns

module tb_kawari_chroma;
   import video_timing_pkg::*;
   import palette_pkg::*;

   localparam int LINE_TICKS  = 1200;   // short test lines
   localparam int CLK_HALF    = 20;
   localparam int RUN_LINES   = 6;
   localparam int WATCHDOG_NS = (RUN_LINES * LINE_TICKS + 1000) * 2 * CLK_HALF;
   localparam logic [31:0] WORD_MASK = 32'h0000_FF3F;   // amp, phase, luma fields

   `include "chroma_ref.svh"

   logic        clk_col16x_ntsc = 1'b0;
   logic        rst;
   color_t      pixel_color;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        pixel_req;
   level_t      luma;
   level_t      chroma;
   logic        luma_sink;

   logic [15:0] shadow_pal [16];   // palette as written over APB
   logic        shadow_en;
   logic [15:0] tb_tick;          // same count as the line timer
   logic [3:0]  tb_phase;
   logic        first_cyc;        // first edge after reset still shows reset state
   expect_t     pipe_q [$];       // 2 samples in flight
   int          seed = 92434;
   int          cyc;
   int          sink_rises;
   int          sink_len;
   int          sink_last;
   int          req_len;
   int          req_runs;
   logic        sink_prev;
   logic        req_prev;
   int          visible_seen;
   int          blanked_seen;

   kawari_chroma #(.LINE_TICKS(LINE_TICKS)) dut0
   (
      .clk_col16x_ntsc(clk_col16x_ntsc),
      .rst            (rst),
      .pixel_color    (pixel_color),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .pixel_req      (pixel_req),
      .luma           (luma),
      .chroma         (chroma),
      .luma_sink      (luma_sink)
   );

   always #CLK_HALF clk_col16x_ntsc = ~clk_col16x_ntsc;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
         abort_run("output differs from the reference");
      end
   endtask

   // one APB transfer with setup and access phase, no wait states
   task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk_col16x_ntsc);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= wdata;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge clk_col16x_ntsc);
      penable <= 1'b1;
      @(posedge clk_col16x_ntsc);
      check_value($sformatf("pready in access phase at %0h", addr), 1, pready);
      rdata   = prdata;   // sampled at the completing edge
      err     = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      apb_access(addr, 1'b1, data, rdata, err);
      check_value($sformatf("pslverr on write to %0h", addr), exp_err, err);
      if (!exp_err && addr == CTRL_ADDR)
         shadow_en <= data[0];   // lands with the DUT register
      else if (!exp_err)
         shadow_pal[addr[5:2]] <= data[15:0] & WORD_MASK[15:0];
   endtask

   task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      apb_access(addr, 1'b0, 32'h0, rdata, err);
      check_value($sformatf("prdata at %0h", addr), exp_data, rdata);
      check_value($sformatf("pslverr on read of %0h", addr), exp_err, err);
   endtask

   // tick and phase counters that restart with reset
   always @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         tb_tick  <= '0;
         tb_phase <= '0;
      end
      else
      begin
         tb_tick  <= (tb_tick == LINE_TICKS - 1) ? 16'd0 : tb_tick + 16'd1;
         tb_phase <= tb_phase + 4'd1;   // never reset by the line
      end
   end

   // new random colour every clock
   always @(posedge clk_col16x_ntsc)
   begin
      int r;
      r = $random(seed);
      pixel_color <= r[3:0];
   end

   // compare process samples now and checks the sample from 2 clocks back
   always @(posedge clk_col16x_ntsc)
   begin
      expect_t exp_now;
      expect_t old;
      int      s_tick;
      int      s_phase;
      if (rst)
      begin
         pipe_q.delete();
         first_cyc <= 1'b1;
      end
      else
      begin
         s_tick  = (tb_tick == 0) ? LINE_TICKS - 1 : tb_tick - 1;   // tick the sequencer shows
         s_phase = (tb_phase + 15) % 16;
         exp_now = ref_expect(s_tick, s_phase, shadow_pal[pixel_color], shadow_en, LINE_TICKS);
         exp_now.valid = !first_cyc;
         first_cyc <= 1'b0;
         if (exp_now.valid)
            check_value($sformatf("pixel_req tick %0d", s_tick), exp_now.req, pixel_req);
         if (pipe_q.size() == 2)
         begin
            old = pipe_q.pop_front();
            if (old.valid)
            begin
               check_value($sformatf("luma tick %0d", old.tick), old.luma, luma);
               check_value($sformatf("chroma tick %0d", old.tick), old.chroma, chroma);
               check_value($sformatf("luma_sink tick %0d", old.tick), old.sink, luma_sink);
               if (old.visible)
                  visible_seen++;
               else if (old.req)
                  blanked_seen++;   // active sample with enable cleared
            end
         end
         pipe_q.push_back(exp_now);
      end
   end

   // pulse widths and spacing from the second line on
   always @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         cyc        <= 0;
         sink_rises <= 0;
         sink_len   <= 0;
         sink_last  <= 0;
         sink_prev  <= 1'b0;
         req_len    <= 0;
         req_runs   <= 0;
         req_prev   <= 1'b0;
      end
      else
      begin
         cyc       <= cyc + 1;
         sink_prev <= luma_sink;
         req_prev  <= pixel_req;
         if (luma_sink && !sink_prev)
         begin
            if (sink_rises >= 2)
               check_value("luma_sink rise spacing", LINE_TICKS, cyc - sink_last);
            sink_rises <= sink_rises + 1;
            sink_last  <= cyc;
            sink_len   <= 1;
         end
         else if (luma_sink)
            sink_len <= sink_len + 1;
         else if (sink_prev && sink_rises >= 2)
            check_value("luma_sink width", SYNC_END, sink_len);
         if (pixel_req)
            req_len <= req_prev ? req_len + 1 : 1;
         else if (req_prev)
         begin
            check_value("pixel_req width", LINE_TICKS - FRONT_PORCH - ACTIVE_START, req_len);
            req_runs <= req_runs + 1;
         end
      end
   end

   // watchdog a little over RUN_LINES lines
   initial
   begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before the test sequence finished");
   end

   initial
   begin
      logic [31:0] wdata [16];
      rst         = 1'b1;
      pixel_color = '0;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      shadow_en   = 1'b0;
      for (int k = 0; k < 16; k++)
      begin
         shadow_pal[k] = '0;
         wdata[k]      = $random(seed);   // unused bits set as well
      end

      repeat (5) @(posedge clk_col16x_ntsc);
      check_value("luma in reset", LUMA_BLANK, luma);
      check_value("chroma in reset", CHROMA_MID, chroma);
      check_value("luma_sink in reset", 0, luma_sink);
      check_value("pixel_req in reset", 0, pixel_req);
      check_value("pslverr in reset", 0, pslverr);
      rst <= 1'b0;

      // APB map reads 0 after reset and then returns what was written
      for (int k = 0; k < 16; k++)
         apb_read(8'(4 * k), 32'h0, 1'b0);
      apb_read(CTRL_ADDR, 32'h0, 1'b0);
      for (int k = 0; k < 16; k++)
         apb_write(8'(4 * k), wdata[k], 1'b0);
      for (int k = 0; k < 16; k++)
         apb_read(8'(4 * k), wdata[k] & WORD_MASK, 1'b0);
      apb_write(CTRL_ADDR, 32'hFFFF_FFFE, 1'b0);   // enable stays 0
      apb_read(CTRL_ADDR, 32'h0, 1'b0);

      // out of map and unaligned accesses
      apb_write(8'h44, 32'hFFFF_FFFF, 1'b1);
      apb_read(8'h44, 32'h0, 1'b1);
      apb_write(8'h06, 32'h0000_FFFF, 1'b1);
      apb_read(8'h06, 32'h0, 1'b1);
      apb_read(8'h04, wdata[1] & WORD_MASK, 1'b0);   // entry 1 untouched
      apb_read(CTRL_ADDR, 32'h0, 1'b0);

      // palette on screen for 3 lines
      apb_write(CTRL_ADDR, 32'h1, 1'b0);
      apb_read(CTRL_ADDR, 32'h1, 1'b0);
      repeat (3 * LINE_TICKS) @(posedge clk_col16x_ntsc);

      // clear enable in the middle of active video
      while (tb_tick != 16'd800)
         @(posedge clk_col16x_ntsc);
      apb_write(CTRL_ADDR, 32'h0, 1'b0);
      repeat (LINE_TICKS + 4) @(posedge clk_col16x_ntsc);

      check_value("enabled active samples compared", 1, visible_seen > 0);
      check_value("blanked active samples compared", 1, blanked_seen > 0);
      check_value("sync pulses measured", 1, sink_rises >= 4);
      check_value("pixel_req runs measured", 1, req_runs >= 4);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* kawari_chroma.f */
+incdir+tb
src/video_timing_pkg.sv
src/palette_pkg.sv
src/seg_if.sv
src/palette_if.sv
src/palette_regs.sv
src/line_timer.sv
src/line_sequencer.sv
src/video_delay.sv
src/chroma_modulator.sv
src/kawari_chroma.sv
tb/tb_kawari_chroma.sv
